// ==== source/rename_geom_pkg.sv ====
// Register file geometry shared by the rename stage: register counts, widths and fixed registers.
`default_nettype none

package rename_geom_pkg;

    // Architectural register file seen by the micro-ops.
    localparam int ARCH_REGS = 16;
    localparam int ARCH_W = 4;

    // Architectural registers 0 and 1 map permanently to physical registers 0 and 1.
    localparam int FIXED_REGS = 2;

    // Physical register count used when the top level is not told otherwise.
    localparam int DEFAULT_PHYS_REGS = 24;

    // Program counter pair written by terminating micro-ops.
    localparam int REG_PCH = 14;
    localparam int REG_PCL = 15;

    typedef logic [ARCH_W-1:0] arch_reg_t;

endpackage

`default_nettype wire

// ==== source/microop_pkg.sv ====
// Micro-op encoding: opcode field, opcode values and destination register fields.
`default_nettype none

package microop_pkg;

    localparam int MICROOP_W = 24;

    // Opcode occupies the top nibble.
    localparam int OPC_HI = 23;
    localparam int OPC_LO = 20;

    // Top bits of the two destination fields, each one register index wide.
    localparam int DST_A_HI = 19;
    localparam int DST_B_HI = 15;

    localparam logic [OPC_HI-OPC_LO:0] OPC_LOAD = 4'd12;
    localparam logic [OPC_HI-OPC_LO:0] OPC_STORE = 4'd13;

    // Both terminating opcodes write the program counter pair.
    localparam logic [OPC_HI-OPC_LO:0] OPC_TERM0 = 4'd14;
    localparam logic [OPC_HI-OPC_LO:0] OPC_TERM1 = 4'd15;

    typedef logic [MICROOP_W-1:0] microop_t;

endpackage

`default_nettype wire

// ==== source/dest_decoder.sv ====
// Destination decoder: maps a micro-op to its two destination registers and rename enables.
`default_nettype none
`timescale 1ns/1ps

module dest_decoder (
    input  microop_pkg::microop_t     uop,
    output rename_geom_pkg::arch_reg_t dst_a,
    output rename_geom_pkg::arch_reg_t dst_b,
    output logic                      en_a,
    output logic                      en_b
);
    import rename_geom_pkg::*;
    import microop_pkg::*;

    logic [OPC_HI-OPC_LO:0] opc;

    assign opc = uop[OPC_HI:OPC_LO];

    always_comb begin
        case (opc)
            // A load only writes the register named in the second field.
            OPC_LOAD: begin
                dst_a = '0;
                dst_b = uop[DST_B_HI -: ARCH_W];
            end
            OPC_STORE: begin
                dst_a = '0;
                dst_b = '0;
            end
            OPC_TERM0, OPC_TERM1: begin
                dst_a = arch_reg_t'(REG_PCH);
                dst_b = arch_reg_t'(REG_PCL);
            end
            default: begin
                dst_a = uop[DST_A_HI -: ARCH_W];
                dst_b = uop[DST_B_HI -: ARCH_W];
            end
        endcase
    end

    // Writes to the hard-wired registers never consume a physical register.
    assign en_a = dst_a >= arch_reg_t'(FIXED_REGS);
    assign en_b = dst_b >= arch_reg_t'(FIXED_REGS);

endmodule

`default_nettype wire

// ==== source/renamer_cell.sv ====
// Renamer cell: allocates one physical register for one destination and updates pool, RAT and mask.
`default_nettype none
`timescale 1ns/1ps

module renamer_cell #(
    parameter int PHYS_REGS = rename_geom_pkg::DEFAULT_PHYS_REGS,
    localparam int PW = $clog2(PHYS_REGS),
    localparam int POOL_W = PHYS_REGS - rename_geom_pkg::FIXED_REGS,
    localparam int RAT_W = rename_geom_pkg::ARCH_REGS * PW
) (
    input  rename_geom_pkg::arch_reg_t arch_reg,
    input  logic                      en,
    input  logic [POOL_W-1:0]         free_pool,
    input  logic [RAT_W-1:0]          rat,
    input  logic [rename_geom_pkg::ARCH_REGS-1:0] mask,
    output logic [POOL_W-1:0]         new_free_pool,
    output logic [RAT_W-1:0]          new_rat,
    output logic [rename_geom_pkg::ARCH_REGS-1:0] new_mask,
    output logic [PW-1:0]             phys_reg,
    output logic [PW-1:0]             prev_phys,
    output logic                      prev_valid,
    output logic                      ok
);
    import rename_geom_pkg::*;

    logic [PW-1:0] pick;
    logic          found;
    logic          does_rename;

    // Lowest-index free register wins; scanning downwards leaves the lowest one last.
    always_comb begin
        pick = '0;
        found = 1'b0;
        for (int i = POOL_W - 1; i >= 0; i--) begin
            if (free_pool[i]) begin
                pick = PW'(i);
                found = 1'b1;
            end
        end
    end

    assign does_rename = en & found;

    assign phys_reg = en ? pick + PW'(FIXED_REGS) : PW'(arch_reg);
    assign prev_phys = rat[arch_reg*PW +: PW];
    assign prev_valid = en & mask[arch_reg];
    assign ok = ~en | found;

    always_comb begin
        new_free_pool = free_pool;
        new_rat = rat;
        new_mask = mask;
        if (does_rename) begin
            new_free_pool[pick] = 1'b0;
            new_rat[arch_reg*PW +: PW] = phys_reg;
            new_mask[arch_reg] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== source/renamer.sv ====
// Renamer: chains two renamer cells so both destinations of a micro-op are renamed together.
`default_nettype none
`timescale 1ns/1ps

module renamer #(
    parameter int PHYS_REGS = rename_geom_pkg::DEFAULT_PHYS_REGS,
    localparam int PW = $clog2(PHYS_REGS),
    localparam int POOL_W = PHYS_REGS - rename_geom_pkg::FIXED_REGS,
    localparam int RAT_W = rename_geom_pkg::ARCH_REGS * PW
) (
    input  logic                      en_a,
    input  logic                      en_b,
    input  rename_geom_pkg::arch_reg_t dst_a,
    input  rename_geom_pkg::arch_reg_t dst_b,
    input  logic [POOL_W-1:0]         free_pool,
    input  logic [RAT_W-1:0]          rat,
    input  logic [rename_geom_pkg::ARCH_REGS-1:0] mask,
    output logic [POOL_W-1:0]         next_free_pool,
    output logic [RAT_W-1:0]          next_rat,
    output logic [rename_geom_pkg::ARCH_REGS-1:0] next_mask,
    output logic [PW-1:0]             phys_a,
    output logic [PW-1:0]             phys_b,
    output logic [PW-1:0]             prev_a,
    output logic [PW-1:0]             prev_b,
    output logic                      prev_valid_a,
    output logic                      prev_valid_b,
    output logic                      rename_ok
);
    import rename_geom_pkg::*;

    logic [POOL_W-1:0]    pool_mid;
    logic [RAT_W-1:0]     rat_mid;
    logic [ARCH_REGS-1:0] mask_mid;
    logic                 ok_a;
    logic                 ok_b;

    renamer_cell #(.PHYS_REGS(PHYS_REGS)) cell_a (
        .arch_reg      (dst_a),
        .en            (en_a),
        .free_pool     (free_pool),
        .rat           (rat),
        .mask          (mask),
        .new_free_pool (pool_mid),
        .new_rat       (rat_mid),
        .new_mask      (mask_mid),
        .phys_reg      (phys_a),
        .prev_phys     (prev_a),
        .prev_valid    (prev_valid_a),
        .ok            (ok_a)
    );

    // Cell B sees cell A's update, so a repeated destination reports A's register as prev.
    renamer_cell #(.PHYS_REGS(PHYS_REGS)) cell_b (
        .arch_reg      (dst_b),
        .en            (en_b),
        .free_pool     (pool_mid),
        .rat           (rat_mid),
        .mask          (mask_mid),
        .new_free_pool (next_free_pool),
        .new_rat       (next_rat),
        .new_mask      (next_mask),
        .phys_reg      (phys_b),
        .prev_phys     (prev_b),
        .prev_valid    (prev_valid_b),
        .ok            (ok_b)
    );

    // The state only moves when both halves fit.
    assign rename_ok = ok_a & ok_b;

endmodule

`default_nettype wire

// ==== source/rename_state.sv ====
// Rename state: free pool, RAT and written mask, updated by commits and retires.
`default_nettype none
`timescale 1ns/1ps

module rename_state #(
    parameter int PHYS_REGS = rename_geom_pkg::DEFAULT_PHYS_REGS,
    localparam int PW = $clog2(PHYS_REGS),
    localparam int POOL_W = PHYS_REGS - rename_geom_pkg::FIXED_REGS,
    localparam int RAT_W = rename_geom_pkg::ARCH_REGS * PW
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              commit,
    input  logic              retire_valid,
    input  logic [PW-1:0]     retire_phys,
    input  logic [POOL_W-1:0] next_free_pool,
    input  logic [RAT_W-1:0]  next_rat,
    input  logic [rename_geom_pkg::ARCH_REGS-1:0] next_mask,
    output logic [POOL_W-1:0] free_pool,
    output logic [RAT_W-1:0]  rat,
    output logic [rename_geom_pkg::ARCH_REGS-1:0] mask
);
    import rename_geom_pkg::*;

    logic [POOL_W-1:0] retire_bits;
    logic [POOL_W-1:0] pool_base;

    // Pool bit i stands for physical register i + 2.
    always_comb begin
        retire_bits = '0;
        if (retire_valid) begin
            retire_bits[retire_phys - PW'(FIXED_REGS)] = 1'b1;
        end
    end

    assign pool_base = commit ? next_free_pool : free_pool;

    always_ff @(posedge clk) begin
        if (reset) begin
            free_pool <= '1;
            mask <= '0;
            for (int i = 0; i < ARCH_REGS; i++) begin
                rat[i*PW +: PW] <= PW'(i);
            end
        end else begin
            // A retire lands on top of whatever the rename did this cycle.
            free_pool <= pool_base | retire_bits;
            if (commit) begin
                rat <= next_rat;
                mask <= next_mask;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/rename_control.sv ====
// Rename control FSM: accepts or holds micro-ops, retries them, and drives stall and results.
`default_nettype none
`timescale 1ns/1ps

module rename_control #(
    parameter int PHYS_REGS = rename_geom_pkg::DEFAULT_PHYS_REGS,
    localparam int PW = $clog2(PHYS_REGS)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  uop_valid,
    input  microop_pkg::microop_t uop,
    input  logic                  rename_ok,
    input  logic [PW-1:0]         phys_a,
    input  logic [PW-1:0]         phys_b,
    input  logic [PW-1:0]         prev_a,
    input  logic [PW-1:0]         prev_b,
    input  logic                  prev_valid_a,
    input  logic                  prev_valid_b,
    output microop_pkg::microop_t held_uop,
    output logic                  commit,
    output logic                  stall,
    output logic                  out_valid,
    output logic [PW-1:0]         dst_phys_a,
    output logic [PW-1:0]         dst_phys_b,
    output logic [PW-1:0]         prev_phys_a,
    output logic [PW-1:0]         prev_phys_b,
    output logic                  out_prev_valid_a,
    output logic                  out_prev_valid_b
);
    import microop_pkg::*;

    typedef enum logic {
        IDLE,
        HOLDING
    } state_t;

    state_t   state;
    microop_t stored_uop;
    logic     present;

    assign held_uop = (state == HOLDING) ? stored_uop : uop;
    assign present = (state == HOLDING) | uop_valid;
    assign commit = present & rename_ok;
    assign stall = state == HOLDING;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else if (state == IDLE && uop_valid && !rename_ok) begin
            state <= HOLDING;
        end else if (state == HOLDING && rename_ok) begin
            state <= IDLE;
        end
    end

    // Captured once on entry to HOLDING; the retries reuse it.
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            stored_uop <= uop;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= commit;
        end
    end

    always_ff @(posedge clk) begin
        if (commit) begin
            dst_phys_a <= phys_a;
            dst_phys_b <= phys_b;
            prev_phys_a <= prev_a;
            prev_phys_b <= prev_b;
            out_prev_valid_a <= prev_valid_a;
            out_prev_valid_b <= prev_valid_b;
        end
    end

endmodule

`default_nettype wire

// ==== source/rename_stage.sv ====
// Register rename stage top level: control, destination decode, renamer and rename state.
`default_nettype none
`timescale 1ns/1ps

module rename_stage #(
    parameter int PHYS_REGS = rename_geom_pkg::DEFAULT_PHYS_REGS,
    localparam int PW = $clog2(PHYS_REGS)
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  uop_valid,
    input  microop_pkg::microop_t uop,
    output logic                  stall,
    output logic                  out_valid,
    output logic [PW-1:0]         dst_phys_a,
    output logic [PW-1:0]         dst_phys_b,
    output logic [PW-1:0]         prev_phys_a,
    output logic [PW-1:0]         prev_phys_b,
    output logic                  prev_valid_a,
    output logic                  prev_valid_b,
    input  logic                  retire_valid,
    input  logic [PW-1:0]         retire_phys
);
    import rename_geom_pkg::*;
    import microop_pkg::*;

    localparam int POOL_W = PHYS_REGS - FIXED_REGS;
    localparam int RAT_W = ARCH_REGS * PW;

    microop_t             held_uop;
    arch_reg_t            dst_a;
    arch_reg_t            dst_b;
    logic                 en_a;
    logic                 en_b;
    logic [POOL_W-1:0]    free_pool;
    logic [POOL_W-1:0]    next_free_pool;
    logic [RAT_W-1:0]     rat;
    logic [RAT_W-1:0]     next_rat;
    logic [ARCH_REGS-1:0] mask;
    logic [ARCH_REGS-1:0] next_mask;
    logic [PW-1:0]        phys_a;
    logic [PW-1:0]        phys_b;
    logic [PW-1:0]        prev_a;
    logic [PW-1:0]        prev_b;
    logic                 cell_prev_valid_a;
    logic                 cell_prev_valid_b;
    logic                 rename_ok;
    logic                 commit;

    rename_control #(.PHYS_REGS(PHYS_REGS)) control_inst (
        .clk              (clk),
        .reset            (reset),
        .uop_valid        (uop_valid),
        .uop              (uop),
        .rename_ok        (rename_ok),
        .phys_a           (phys_a),
        .phys_b           (phys_b),
        .prev_a           (prev_a),
        .prev_b           (prev_b),
        .prev_valid_a     (cell_prev_valid_a),
        .prev_valid_b     (cell_prev_valid_b),
        .held_uop         (held_uop),
        .commit           (commit),
        .stall            (stall),
        .out_valid        (out_valid),
        .dst_phys_a       (dst_phys_a),
        .dst_phys_b       (dst_phys_b),
        .prev_phys_a      (prev_phys_a),
        .prev_phys_b      (prev_phys_b),
        .out_prev_valid_a (prev_valid_a),
        .out_prev_valid_b (prev_valid_b)
    );

    dest_decoder decoder_inst (
        .uop   (held_uop),
        .dst_a (dst_a),
        .dst_b (dst_b),
        .en_a  (en_a),
        .en_b  (en_b)
    );

    renamer #(.PHYS_REGS(PHYS_REGS)) renamer_inst (
        .en_a           (en_a),
        .en_b           (en_b),
        .dst_a          (dst_a),
        .dst_b          (dst_b),
        .free_pool      (free_pool),
        .rat            (rat),
        .mask           (mask),
        .next_free_pool (next_free_pool),
        .next_rat       (next_rat),
        .next_mask      (next_mask),
        .phys_a         (phys_a),
        .phys_b         (phys_b),
        .prev_a         (prev_a),
        .prev_b         (prev_b),
        .prev_valid_a   (cell_prev_valid_a),
        .prev_valid_b   (cell_prev_valid_b),
        .rename_ok      (rename_ok)
    );

    rename_state #(.PHYS_REGS(PHYS_REGS)) state_inst (
        .clk            (clk),
        .reset          (reset),
        .commit         (commit),
        .retire_valid   (retire_valid),
        .retire_phys    (retire_phys),
        .next_free_pool (next_free_pool),
        .next_rat       (next_rat),
        .next_mask      (next_mask),
        .free_pool      (free_pool),
        .rat            (rat),
        .mask           (mask)
    );

endmodule

`default_nettype wire

// ==== bench/rename_stage_chk.sv ====
// Rename stage checker: concurrent assertions on stall, out_valid and allocated registers.
`default_nettype none
`timescale 1ns/1ps

module rename_stage_chk #(
    parameter int PW = 5
) (
    input logic          clk,
    input logic          reset,
    input logic          uop_valid,
    input logic          stall,
    input logic          out_valid,
    input logic          commit,
    input logic          en_a,
    input logic          en_b,
    input logic [PW-1:0] phys_a,
    input logic [PW-1:0] phys_b
);

    // Upstream holds off while a micro-op waits.
    assert property (@(posedge clk) disable iff (reset) !(stall && uop_valid))
        else $error("uop_valid asserted while stall is high");

    assert property (@(posedge clk) reset |=> !out_valid)
        else $error("out_valid high during reset");

    // A renamed destination never lands on a hard-wired register.
    assert property (@(posedge clk) disable iff (reset) (commit && en_a) |-> phys_a >= 2)
        else $error("destination A renamed to a fixed register");

    assert property (@(posedge clk) disable iff (reset) (commit && en_b) |-> phys_b >= 2)
        else $error("destination B renamed to a fixed register");

endmodule

bind rename_stage rename_stage_chk #(.PW(PW)) chk_inst (
    .clk       (clk),
    .reset     (reset),
    .uop_valid (uop_valid),
    .stall     (stall),
    .out_valid (out_valid),
    .commit    (commit),
    .en_a      (en_a),
    .en_b      (en_b),
    .phys_a    (phys_a),
    .phys_b    (phys_b)
);

`default_nettype wire

// ==== bench/rename_stage_tb.sv ====
// Rename stage testbench: LFSR stimulus, cycle model of pool, RAT and mask, and result compare.
`default_nettype none
`timescale 1ns/1ps

module rename_stage_tb;
    import rename_geom_pkg::*;
    import microop_pkg::*;

    localparam int PHYS_REGS = 24;
    localparam int PW = $clog2(PHYS_REGS);
    localparam int POOL_W = PHYS_REGS - FIXED_REGS;

    typedef struct packed {
        logic [PW-1:0] pa;
        logic [PW-1:0] pb;
        logic [PW-1:0] ppa;
        logic [PW-1:0] ppb;
        logic          pva;
        logic          pvb;
    } result_t;

    logic clk;
    logic reset;
    logic uop_valid;
    microop_t uop;
    logic retire_valid;
    logic [PW-1:0] retire_phys;
    logic stall;
    logic out_valid;
    logic [PW-1:0] dst_phys_a;
    logic [PW-1:0] dst_phys_b;
    logic [PW-1:0] prev_phys_a;
    logic [PW-1:0] prev_phys_b;
    logic prev_valid_a;
    logic prev_valid_b;

    // Model state mirrors the DUT's pool, RAT and written mask.
    logic [POOL_W-1:0] m_pool;
    int m_rat[ARCH_REGS];
    logic [ARCH_REGS-1:0] m_mask;
    logic m_hold;
    microop_t m_uop;
    result_t exp_q[$];
    int retire_q[$];
    logic [15:0] lfsr = 16'd2508;

    rename_stage #(.PHYS_REGS(PHYS_REGS)) rename_stage_inst (
        .clk          (clk),
        .reset        (reset),
        .uop_valid    (uop_valid),
        .uop          (uop),
        .stall        (stall),
        .out_valid    (out_valid),
        .dst_phys_a   (dst_phys_a),
        .dst_phys_b   (dst_phys_b),
        .prev_phys_a  (prev_phys_a),
        .prev_phys_b  (prev_phys_b),
        .prev_valid_a (prev_valid_a),
        .prev_valid_b (prev_valid_b),
        .retire_valid (retire_valid),
        .retire_phys  (retire_phys)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr[0];
        lfsr = lfsr >> 1;
        if (lsb) lfsr = lfsr ^ 16'hB400;
        return lsb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit());
        return v;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopping after the first error.");
    endtask

    task automatic check_value(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, expected);
            fail_run("Result mismatch.");
        end
    endtask

    // Expected rename of one micro-op; the model state moves only when both destinations fit.
    function automatic bit rename_ref(input microop_t u, output result_t res);
        int dst[2];
        int phys[2];
        int prev[2];
        bit pv[2];
        int pick;
        int rat_c[ARCH_REGS];
        logic [POOL_W-1:0] pool;
        logic [ARCH_REGS-1:0] msk;
        pool = m_pool;
        rat_c = m_rat;
        msk = m_mask;
        case (u[23:20])
            4'd12: begin
                dst[0] = 0;
                dst[1] = int'(u[15:12]);
            end
            4'd13: begin
                dst[0] = 0;
                dst[1] = 0;
            end
            4'd14, 4'd15: begin
                dst[0] = 14;
                dst[1] = 15;
            end
            default: begin
                dst[0] = int'(u[19:16]);
                dst[1] = int'(u[15:12]);
            end
        endcase
        for (int k = 0; k < 2; k++) begin
            phys[k] = dst[k];
            prev[k] = rat_c[dst[k]];
            pv[k] = 1'b0;
            if (dst[k] >= 2) begin
                pick = -1;
                for (int i = POOL_W - 1; i >= 0; i--) if (pool[i]) pick = i;
                if (pick < 0) return 1'b0;
                phys[k] = pick + 2;
                pv[k] = msk[dst[k]];
                pool[pick] = 1'b0;
                rat_c[dst[k]] = phys[k];
                msk[dst[k]] = 1'b1;
            end
        end
        m_pool = pool;
        m_rat = rat_c;
        m_mask = msk;
        res = {PW'(phys[0]), PW'(phys[1]), PW'(prev[0]), PW'(prev[1]), pv[0], pv[1]};
        return 1'b1;
    endfunction

    // Cycle model: samples the inputs the DUT sees at each edge.
    always @(posedge clk) begin : model_step
        result_t r;
        microop_t u;
        if (reset) begin
            m_pool = '1;
            m_mask = '0;
            m_hold = 1'b0;
            for (int i = 0; i < ARCH_REGS; i++) m_rat[i] = i;
        end else begin
            check_value("stall", int'(stall), int'(m_hold));
            u = m_hold ? m_uop : uop;
            if (m_hold || uop_valid) begin
                if (rename_ref(u, r)) begin
                    exp_q.push_back(r);
                    m_hold = 1'b0;
                    if (r.pva) retire_q.push_back(int'(r.ppa));
                    if (r.pvb) retire_q.push_back(int'(r.ppb));
                end else if (!m_hold) begin
                    m_hold = 1'b1;
                    m_uop = uop;
                end
            end
            if (retire_valid) m_pool[int'(retire_phys) - 2] = 1'b1;
        end
    end

    always @(posedge clk) begin : compare_results
        result_t e;
        if (!reset && out_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("out_valid pulsed when no rename was expected.");
            end else begin
                e = exp_q.pop_front();
                check_value("dst_phys_a", int'(dst_phys_a), int'(e.pa));
                check_value("dst_phys_b", int'(dst_phys_b), int'(e.pb));
                check_value("prev_phys_a", int'(prev_phys_a), int'(e.ppa));
                check_value("prev_phys_b", int'(prev_phys_b), int'(e.ppb));
                check_value("prev_valid_a", int'(prev_valid_a), int'(e.pva));
                check_value("prev_valid_b", int'(prev_valid_b), int'(e.pvb));
            end
        end
    end

    task automatic drive_step(input bit v, input microop_t u, input bit rv, input int rp);
        @(posedge clk);
        uop_valid <= v;
        uop <= u;
        retire_valid <= rv;
        retire_phys <= PW'(rp);
        @(posedge clk);
        uop_valid <= 1'b0;
        retire_valid <= 1'b0;
    endtask

    // Returns on out_valid, or on stall when retires are not allowed.
    task automatic wait_result(input bit allow_retire, output bit stalled);
        int cycles;
        int p;
        bit done;
        bit do_retire;
        cycles = 0;
        p = 2;
        done = 1'b0;
        stalled = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            do_retire = 1'b0;
            if (out_valid) begin
                done = 1'b1;
            end else if (stall && !allow_retire) begin
                stalled = 1'b1;
                done = 1'b1;
            end else if (stall) begin
                if (retire_q.size() == 0) fail_run("Stalled with no register left to retire.");
                p = retire_q.pop_front();
                do_retire = 1'b1;
            end
            if (cycles > 200) fail_run("Timed out waiting for a rename result.");
            // At most one register goes back to the pool each cycle.
            @(posedge clk);
            retire_valid <= do_retire;
            retire_phys <= PW'(p);
        end
    endtask

    task automatic rename_one(input microop_t u, input bit with_retire);
        bit stalled;
        int p;
        p = 2;
        if (with_retire && retire_q.size() > 0) p = retire_q.pop_front();
        else with_retire = 1'b0;
        drive_step(1'b1, u, with_retire, p);
        wait_result(1'b1, stalled);
    endtask

    initial begin
        bit stalled;
        int n;
        microop_t u;
        reset = 1'b1;
        uop_valid = 1'b0;
        uop = '0;
        retire_valid = 1'b0;
        retire_phys = '0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Each opcode class, a repeated destination and a write to the fixed registers.
        rename_one({4'd12, 4'd0, 4'd5, 12'h000}, 1'b0);
        rename_one({4'd13, 4'd6, 4'd7, 12'h000}, 1'b0);
        rename_one({4'd14, 4'd0, 4'd0, 12'h000}, 1'b0);
        rename_one({4'd3, 4'd7, 4'd8, 12'h000}, 1'b0);
        rename_one({4'd3, 4'd9, 4'd9, 12'h000}, 1'b0);
        rename_one({4'd2, 4'd1, 4'd0, 12'h000}, 1'b0);
        rename_one({4'd4, 4'd5, 4'd7, 12'h000}, 1'b0);

        // Exhaust the pool with retires held back, then release it.
        stalled = 1'b0;
        n = 0;
        while (!stalled) begin
            u = {4'd1, 4'(2 + rand_bits(3)), 4'(8 + rand_bits(3)), 12'h000};
            drive_step(1'b1, u, 1'b0, 2);
            wait_result(1'b0, stalled);
            n++;
            if (n > 40) fail_run("The pool never ran out.");
        end
        wait_result(1'b1, stalled);

        // Rename and retire in the same cycle, then a long mixed run.
        rename_one({4'd5, 4'd10, 4'd11, 12'h000}, 1'b1);
        rename_one({4'd5, 4'd12, 4'd13, 12'h000}, 1'b1);
        for (int i = 0; i < 400; i++) begin
            u = {4'(rand_bits(4)), 4'(rand_bits(4)), 4'(rand_bits(4)), 12'h000};
            rename_one(u, lfsr_bit());
        end

        repeat (3) @(negedge clk);
        if (exp_q.size() != 0) begin
            fail_run("An expected rename result never appeared.");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rename_stage.f ====
source/rename_geom_pkg.sv
source/microop_pkg.sv
source/dest_decoder.sv
source/renamer_cell.sv
source/renamer.sv
source/rename_state.sv
source/rename_control.sv
source/rename_stage.sv
bench/rename_stage_chk.sv
bench/rename_stage_tb.sv

// ==== run.sh ====
#!/bin/bash
# Builds the rename stage testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rename_stage_tb \
    -f rename_stage.f -Mdir obj_dir > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vrename_stage_tb > sim.log 2>&1
cat sim.log

grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
